// ==== filelist.f ====
source/scratchpadCfgPkg.sv
source/scratchpadBusPkg.sv
source/ramInitializer.sv
source/bankWriteDecode.sv
source/ramBank.sv
source/readReturnSelect.sv
source/scratchpadTop.sv
testbench/tbClock.sv
testbench/ramInitializer_properties.sv
testbench/scratchpadTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Build the scratchpad testbench with Verilator, run it, and look for the pass message.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module scratchpadTb \
    -Mdir obj_dir -f filelist.f; then
  echo "Verilator build failed"
  exit 1
fi

simOut=$(./obj_dir/VscratchpadTb)
simStatus=$?
printf '%s\n' "$simOut"

if [ "$simStatus" -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if printf '%s\n' "$simOut" | grep -q 'All tests passed!'; then
  exit 0
fi
exit 1

// ==== source/bankWriteDecode.sv ====
// Bank write decoder that broadcasts sweep writes and routes host writes to the addressed bank.
`timescale 1ns/1ps

module bankWriteDecode (
  input  scratchpadCfgPkg::bankAddrT  initWrAddr,
  input  scratchpadCfgPkg::dataT      initWrData,
  input  logic                        initWrValid,
  input  scratchpadBusPkg::hostWriteT hostWrite,
  output scratchpadBusPkg::bankWriteT bankWrite [scratchpadCfgPkg::NumBanks]
);

  scratchpadCfgPkg::bankSelT  hostSel;
  scratchpadCfgPkg::bankAddrT hostWord;

  // Upper address bits name the bank, lower bits the word inside it.
  assign hostSel  = hostWrite.addr[scratchpadCfgPkg::HostAddrWidth-1:
                                   scratchpadCfgPkg::BankAddrWidth];
  assign hostWord = hostWrite.addr[scratchpadCfgPkg::BankAddrWidth-1:0];

  // A sweep write owns every bank for that cycle.
  // Any host write in the same cycle is lost.
  always_comb begin
    for (int i = 0; i < scratchpadCfgPkg::NumBanks; i++) begin
      if (initWrValid) begin
        bankWrite[i].enable = 1'b1;
        bankWrite[i].addr   = initWrAddr;
        bankWrite[i].data   = initWrData;
      end else begin
        bankWrite[i].enable = hostWrite.strobe &&
                              (hostSel == scratchpadCfgPkg::bankSelT'(i));
        bankWrite[i].addr   = hostWord;
        bankWrite[i].data   = hostWrite.data;
      end
    end
  end

endmodule

// ==== source/ramBank.sv ====
// Single scratchpad bank: single-port synchronous RAM with a registered read word.
`timescale 1ns/1ps

module ramBank (
  input  logic                        clk,
  input  scratchpadBusPkg::bankWriteT write,
  input  scratchpadCfgPkg::bankAddrT  rdAddr,
  output scratchpadCfgPkg::dataT      rdData
);

  scratchpadCfgPkg::dataT mem [scratchpadCfgPkg::BankDepth];

  // Write lands on the enabled edge.
  always_ff @(posedge clk) begin
    if (write.enable) begin
      mem[write.addr] <= write.data;
    end
  end

  // The read samples the array every cycle.
  // A write to the same word at this edge is seen on the next read only.
  always_ff @(posedge clk) begin
    rdData <= mem[rdAddr];
  end

endmodule

// ==== source/ramInitializer.sv ====
// RAM initializer that sweeps every word address once after a start strobe and writes a fixed value.
`timescale 1ns/1ps

module ramInitializer #(
  parameter int Depth = scratchpadCfgPkg::BankDepth,
  parameter int Width = scratchpadCfgPkg::DataWidth,
  localparam int AddrWidth = (Depth > 1) ? $clog2(Depth) : 1
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [Width-1:0]     initialValue,
  input  logic                 start,
  output logic                 busy,
  output logic                 wrValid,
  output logic [AddrWidth-1:0] wrAddr,
  output logic [Width-1:0]     wrData
);

  typedef enum logic {
    stateIdle,
    stateSweep
  } initStateT;

  localparam logic [AddrWidth-1:0] LastAddr = AddrWidth'(Depth - 1);

  initStateT            state;
  logic [AddrWidth-1:0] addrQ;

  // The counter starts at zero on the start strobe and steps once per cycle.
  // After the last address the machine drops back to idle.
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= stateIdle;
      addrQ <= '0;
    end else begin
      case (state)
        stateIdle: begin
          addrQ <= '0;
          if (start) begin
            state <= stateSweep;
          end
        end
        stateSweep: begin
          if (addrQ == LastAddr) begin
            state <= stateIdle;
            addrQ <= '0;
          end else begin
            addrQ <= addrQ + 1'b1;
          end
        end
        default: state <= stateIdle;
      endcase
    end
  end

  // Every sweeping cycle is a write, so busy and write-valid are the same level.
  assign busy    = (state == stateSweep);
  assign wrValid = busy;
  assign wrAddr  = addrQ;
  assign wrData  = busy ? initialValue : '0;

endmodule

// ==== source/readReturnSelect.sv ====
// Read return path that picks the addressed bank's word and registers it with a valid bit.
`timescale 1ns/1ps

module readReturnSelect (
  input  logic                         clk,
  input  logic                         rst,
  input  scratchpadBusPkg::hostReadT   hostRead,
  input  scratchpadCfgPkg::dataT       bankData [scratchpadCfgPkg::NumBanks],
  output scratchpadBusPkg::readReturnT readReturn
);

  logic                      rdPendQ;
  scratchpadCfgPkg::bankSelT selQ;
  logic                      retValidQ;
  scratchpadCfgPkg::dataT    retDataQ;

  // First stage runs alongside the registered bank read.
  always_ff @(posedge clk) begin
    if (rst) begin
      rdPendQ <= 1'b0;
    end else begin
      rdPendQ <= hostRead.strobe;
    end
  end

  always_ff @(posedge clk) begin
    selQ <= hostRead.addr[scratchpadCfgPkg::HostAddrWidth-1:scratchpadCfgPkg::BankAddrWidth];
  end

  // Second stage picks the bank word that the first stage pointed at.
  always_ff @(posedge clk) begin
    if (rst) begin
      retValidQ <= 1'b0;
    end else begin
      retValidQ <= rdPendQ;
    end
  end

  always_ff @(posedge clk) begin
    retDataQ <= bankData[selQ];
  end

  assign readReturn.valid = retValidQ;
  assign readReturn.data  = retDataQ;

endmodule

// ==== source/scratchpadBusPkg.sv ====
// Scratchpad bus structs for host requests, per-bank write ports and read returns.
package scratchpadBusPkg;

  // One host write request, valid for the single cycle its strobe is high.
  typedef struct packed {
    logic                        strobe;
    scratchpadCfgPkg::hostAddrT  addr;
    scratchpadCfgPkg::dataT      data;
  } hostWriteT;

  // One host read request.
  // The result comes back two cycles later on the read return.
  typedef struct packed {
    logic                        strobe;
    scratchpadCfgPkg::hostAddrT  addr;
  } hostReadT;

  // Write port of a single bank.
  typedef struct packed {
    logic                        enable;
    scratchpadCfgPkg::bankAddrT  addr;
    scratchpadCfgPkg::dataT      data;
  } bankWriteT;

  // One read result, valid for a single cycle.
  typedef struct packed {
    logic                        valid;
    scratchpadCfgPkg::dataT      data;
  } readReturnT;

endpackage

// ==== source/scratchpadCfgPkg.sv ====
// Scratchpad configuration: bank count, bank depth, word width and the derived address widths.
package scratchpadCfgPkg;

  // Number of identical banks behind the flat host address.
  localparam int NumBanks = 4;

  // Words held by each bank.
  localparam int BankDepth = 16;

  // Bits per stored word.
  localparam int DataWidth = 8;

  // Word address inside one bank.
  localparam int BankAddrWidth = $clog2(BankDepth);

  // Bank number taken from the upper host address bits.
  localparam int BankSelWidth = $clog2(NumBanks);

  // Flat host address, bank select on top of the word address.
  localparam int HostAddrWidth = BankSelWidth + BankAddrWidth;

  // One stored word.
  typedef logic [DataWidth-1:0] dataT;

  // Word address within a bank.
  typedef logic [BankAddrWidth-1:0] bankAddrT;

  // Bank number.
  typedef logic [BankSelWidth-1:0] bankSelT;

  // Flat host address. Upper bits pick the bank, lower bits pick the word.
  typedef logic [HostAddrWidth-1:0] hostAddrT;

endpackage

// ==== source/scratchpadTop.sv ====
// Banked scratchpad RAM top level with a start-triggered initializer and a two-cycle read path.
`timescale 1ns/1ps

module scratchpadTop (
  input  logic                         clk,
  input  logic                         rst,
  input  scratchpadCfgPkg::dataT       initValue,
  input  logic                         initStart,
  output logic                         initBusy,
  input  scratchpadBusPkg::hostWriteT  hostWrite,
  input  scratchpadBusPkg::hostReadT   hostRead,
  output scratchpadBusPkg::readReturnT readReturn
);

  logic                        initWrValid;
  scratchpadCfgPkg::bankAddrT  initWrAddr;
  scratchpadCfgPkg::dataT      initWrData;
  scratchpadBusPkg::bankWriteT bankWrite [scratchpadCfgPkg::NumBanks];
  scratchpadCfgPkg::dataT      bankRdData [scratchpadCfgPkg::NumBanks];
  scratchpadCfgPkg::bankAddrT  rdWordAddr;

  ramInitializer #(
    .Depth(scratchpadCfgPkg::BankDepth),
    .Width(scratchpadCfgPkg::DataWidth)
  ) i_initializer (
    .clk         (clk),
    .rst         (rst),
    .initialValue(initValue),
    .start       (initStart),
    .busy        (initBusy),
    .wrValid     (initWrValid),
    .wrAddr      (initWrAddr),
    .wrData      (initWrData)
  );

  bankWriteDecode i_writeDecode (
    .initWrAddr (initWrAddr),
    .initWrData (initWrData),
    .initWrValid(initWrValid),
    .hostWrite  (hostWrite),
    .bankWrite  (bankWrite)
  );

  // All banks read the same word; the selector keeps only the addressed one.
  assign rdWordAddr = hostRead.addr[scratchpadCfgPkg::BankAddrWidth-1:0];

  for (genvar b = 0; b < scratchpadCfgPkg::NumBanks; b++) begin : genBank
    ramBank i_bank (
      .clk   (clk),
      .write (bankWrite[b]),
      .rdAddr(rdWordAddr),
      .rdData(bankRdData[b])
    );
  end

  readReturnSelect i_readSelect (
    .clk       (clk),
    .rst       (rst),
    .hostRead  (hostRead),
    .bankData  (bankRdData),
    .readReturn(readReturn)
  );

endmodule

// ==== testbench/ramInitializer_properties.sv ====
// Concurrent assertions on the RAM initializer sweep, bound into every ramInitializer instance.
`timescale 1ns/1ps

module ramInitializerProperties #(
  parameter int Depth = scratchpadCfgPkg::BankDepth,
  parameter int Width = scratchpadCfgPkg::DataWidth,
  localparam int AddrWidth = (Depth > 1) ? $clog2(Depth) : 1
) (
  input logic                 clk,
  input logic                 rst,
  input logic [Width-1:0]     initialValue,
  input logic                 busy,
  input logic                 wrValid,
  input logic [AddrWidth-1:0] wrAddr,
  input logic [Width-1:0]     wrData
);

  localparam logic [AddrWidth-1:0] LastAddr = AddrWidth'(Depth - 1);

  validOnlyWhenBusy: assert property (@(posedge clk) disable iff (rst)
    wrValid |-> busy)
    else $error("initializer write-valid high while not busy");

  dataIsInitialValue: assert property (@(posedge clk) disable iff (rst)
    wrValid |-> (wrData == initialValue))
    else $error("initializer write data differs from the initial value");

  // Starting at zero, stepping by one and ending at the last address gives exactly Depth cycles.
  addrZeroOnRise: assert property (@(posedge clk) disable iff (rst)
    $rose(busy) |-> (wrAddr == '0))
    else $error("initializer sweep did not start at address zero");

  addrSteps: assert property (@(posedge clk) disable iff (rst)
    (busy && $past(busy)) |-> (wrAddr == $past(wrAddr) + 1'b1))
    else $error("initializer address did not step by one");

  busyEndsAfterLast: assert property (@(posedge clk) disable iff (rst)
    (busy && (wrAddr == LastAddr)) |=> !busy)
    else $error("initializer busy stayed high past the last address");

  busyFallsAtLast: assert property (@(posedge clk) disable iff (rst)
    $fell(busy) |-> ($past(wrAddr) == LastAddr))
    else $error("initializer busy fell before the last address");

endmodule

bind ramInitializer ramInitializerProperties #(
  .Depth(Depth),
  .Width(Width)
) i_properties (
  .clk         (clk),
  .rst         (rst),
  .initialValue(initialValue),
  .busy        (busy),
  .wrValid     (wrValid),
  .wrAddr      (wrAddr),
  .wrData      (wrData)
);

// ==== testbench/scratchpadTb.sv ====
// Scratchpad testbench that replays the command file on the DUT and checks every read return.
`timescale 1ns/1ps

module scratchpadTb;

  localparam string DataFile      = "testbench/testdata.txt";
  localparam int    ResetCycles   = 16;
  localparam int    TimeoutCycles = 100;
  localparam int    DriveDelayNs  = 1;
  localparam int    ReadLatency   = 2;

  logic                         clk;
  logic                         rst;
  scratchpadCfgPkg::dataT       initValue;
  logic                         initStart;
  logic                         initBusy;
  scratchpadBusPkg::hostWriteT  hostWrite;
  scratchpadBusPkg::hostReadT   hostRead;
  scratchpadBusPkg::readReturnT readReturn;

  // Expected read words and their addresses, in issue order.
  scratchpadCfgPkg::dataT   expectedData [$];
  scratchpadCfgPkg::hostAddrT expectedAddr [$];

  // Clock edge at which each read strobe is sampled.
  int issueCycle [$];

  int errorCount     = 0;
  int timeoutCount   = 0;
  int readErrorCount = 0;
  int returnCount    = 0;
  int cycleCount     = 0;
  bit stopRun        = 1'b0;

  tbClock i_clock (
    .clk(clk)
  );

  scratchpadTop i_dut (
    .clk       (clk),
    .rst       (rst),
    .initValue (initValue),
    .initStart (initStart),
    .initBusy  (initBusy),
    .hostWrite (hostWrite),
    .hostRead  (hostRead),
    .readReturn(readReturn)
  );

  always @(posedge clk) begin
    cycleCount++;
  end

  task automatic nextCycle();
    @(posedge clk);
    #(DriveDelayNs);
  endtask

  task automatic startSweep(input scratchpadCfgPkg::dataT value);
    initValue = value;
    initStart = 1'b1;
    nextCycle();
    initStart = 1'b0;
    if (initBusy !== 1'b1) begin
      $display("** Error at %0t: initBusy expected 1, got %b", $time, initBusy);
      errorCount++;
    end
  endtask

  task automatic waitSweepDone();
    int cycles;
    cycles = 0;
    while (initBusy === 1'b1 && cycles < TimeoutCycles) begin
      nextCycle();
      cycles++;
    end
    if (initBusy !== 1'b0) begin
      $display("Timeout: initBusy did not fall after %0d cycles", TimeoutCycles);
      timeoutCount++;
      stopRun = 1'b1;
    end
  endtask

  task automatic writeWord(input scratchpadCfgPkg::hostAddrT addr,
                           input scratchpadCfgPkg::dataT data);
    hostWrite = '{strobe: 1'b1, addr: addr, data: data};
    nextCycle();
    hostWrite.strobe = 1'b0;
  endtask

  task automatic readWord(input scratchpadCfgPkg::hostAddrT addr,
                          input scratchpadCfgPkg::dataT expected);
    expectedData.push_back(expected);
    expectedAddr.push_back(addr);
    issueCycle.push_back(cycleCount + 1);
    hostRead = '{strobe: 1'b1, addr: addr};
    nextCycle();
    hostRead.strobe = 1'b0;
  endtask

  task automatic waitReadsDone();
    int cycles;
    cycles = 0;
    while (returnCount < expectedData.size() && cycles < TimeoutCycles) begin
      nextCycle();
      cycles++;
    end
    if (returnCount < expectedData.size()) begin
      $display("Timeout: readReturn valid missing for %0d outstanding reads",
               expectedData.size() - returnCount);
      timeoutCount++;
      stopRun = 1'b1;
    end
  endtask

  task automatic finishRun();
    $display("Run complete: %0d errors, %0d timeouts", errorCount + readErrorCount,
             timeoutCount);
    if (errorCount == 0 && readErrorCount == 0 && timeoutCount == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  endtask

  // Read returns are checked on the falling edge, away from the DUT's register updates.
  // The valid seen here is sampled at the next rising edge.
  always @(negedge clk) begin
    if (!rst && readReturn.valid === 1'b1) begin
      if (returnCount >= expectedData.size()) begin
        $display("Read return at %0t arrived with no read outstanding", $time);
        readErrorCount++;
      end else begin
        if (readReturn.data !== expectedData[returnCount]) begin
          $display("** Error at %0t: readReturn.data for address 0x%h expected 0x%h, got 0x%h",
                   $time, expectedAddr[returnCount], expectedData[returnCount],
                   readReturn.data);
          readErrorCount++;
        end
        if (cycleCount + 1 - issueCycle[returnCount] != ReadLatency) begin
          $display("** Error at %0t: readReturn.valid latency for address 0x%h %s %0d, got %0d",
                   $time, expectedAddr[returnCount], "expected", ReadLatency,
                   cycleCount + 1 - issueCycle[returnCount]);
          readErrorCount++;
        end
      end
      returnCount++;
    end
  end

  initial begin : mainFlow
    int          fd;
    int          fields;
    string       line;
    byte         cmd;
    logic [31:0] argA;
    logic [31:0] argB;
    rst       = 1'b1;
    initValue = '0;
    initStart = 1'b0;
    hostWrite = '0;
    hostRead  = '0;
    repeat (ResetCycles) @(posedge clk);
    #(DriveDelayNs);
    rst = 1'b0;
    if (initBusy !== 1'b0) begin
      $display("** Error at %0t: initBusy expected 0, got %b", $time, initBusy);
      errorCount++;
    end
    if (readReturn.valid !== 1'b0) begin
      $display("** Error at %0t: readReturn.valid expected 0, got %b", $time,
               readReturn.valid);
      errorCount++;
    end
    fd = $fopen(DataFile, "r");
    if (fd == 0) begin
      $display("Could not open the test data file %s", DataFile);
      errorCount++;
    end
    while (!stopRun && fd != 0 && $fgets(line, fd) != 0) begin
      if (line.len() > 1 && line.getc(0) != "#") begin
        cmd    = line.getc(0);
        argA   = '0;
        argB   = '0;
        fields = $sscanf(line.substr(1, line.len() - 1), "%h %h", argA, argB);
        case (cmd)
          "S": startSweep(scratchpadCfgPkg::dataT'(argA));
          "B": waitSweepDone();
          "W": writeWord(scratchpadCfgPkg::hostAddrT'(argA), scratchpadCfgPkg::dataT'(argB));
          "R": readWord(scratchpadCfgPkg::hostAddrT'(argA), scratchpadCfgPkg::dataT'(argB));
          "I": repeat (int'(argA)) nextCycle();
          default: begin
            $display("Unknown command in test data, %0d fields: %s", fields, line);
            errorCount++;
          end
        endcase
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    if (!stopRun) begin
      waitReadsDone();
    end
    finishRun();
  end

endmodule

// ==== testbench/tbClock.sv ====
// Testbench clock generator that drives a free-running 4 ns clock.
`timescale 1ns/1ps

module tbClock #(
  parameter int HalfPeriodNs = 2
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always begin
    #(HalfPeriodNs) clk = ~clk;
  end

endmodule

// ==== testbench/testdata.txt ====
# Command letter then hex values: S value, B, W addr data, R addr expected, I cycles.
# S starts a sweep, B waits for busy to fall, W writes, R reads and checks, I idles.
S 5a
W 10 ff
B
R 00 5a
R 0f 5a
R 10 5a
R 1f 5a
R 20 5a
R 3f 5a
W 03 11
W 13 22
W 23 33
R 03 11
R 13 22
R 23 33
R 33 5a
I 4
S a5
B
R 03 a5
R 13 a5
R 23 a5
R 3f a5
